/* sim/tb_switch_rx_port.sv */
`default_nettype none

module tb_switch_rx_port import eth_pkg::*, switch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int     SW_PERIOD   = 40;
    localparam int     GMII_PERIOD = 48;  // slower than the switch side
    localparam port_t  TB_PORT     = 3'd5;
    localparam int     N_FRAMES    = 16;
    localparam int     MAX_PAYLOAD = 35;
    localparam int     IFG         = 12;  // idle gmii cycles between frames
    localparam int     FRAME_SLOT  = PREAMBLE_LEN + 1 + 12 + MAX_PAYLOAD + 4 + IFG;
    localparam longint WATCHDOG_NS = N_FRAMES * FRAME_SLOT * GMII_PERIOD * 4 + 20000;

    // frame variants for send_frame
    localparam int GOOD    = 0;
    localparam int BAD_FCS = 1;
    localparam int RX_ER   = 2;
    localparam int BAD_PRE = 3;
    localparam int BAD_SFD = 4;

    localparam mac_addr_t ADDR_A  = 48'h02_00_00_00_00_0A;
    localparam mac_addr_t ADDR_B  = 48'h02_00_00_00_00_0B;
    localparam mac_addr_t ADDR_C  = 48'h02_00_00_00_00_0C;
    localparam mac_addr_t ADDR_D  = 48'h02_00_00_00_00_0D;
    localparam mac_addr_t ADDR_E  = 48'h02_00_00_00_00_0E;
    localparam mac_addr_t ADDR_F  = 48'h02_00_00_00_00_0F;  // never learned
    localparam mac_addr_t ADDR_U  = 48'h02_00_00_00_77_01;
    localparam mac_addr_t BCAST   = 48'hFF_FF_FF_FF_FF_FF;

    logic      switch_clk;
    logic      switch_rst_n;
    logic      gmii_rx_clk_i;
    byte_t     gmii_rx_data_i;
    logic      gmii_rx_dv_i;
    logic      gmii_rx_er_i;
    byte_t     frame_data_o;
    logic      frame_valid_o;
    logic      frame_ready_i;
    logic      frame_sof_o;
    logic      frame_eof_o;
    logic      frame_error_o;
    mac_addr_t mac_dst_addr_o;
    mac_addr_t mac_src_addr_o;
    logic      lookup_valid_o;
    logic      lookup_ready_i;
    port_t     lookup_port_o;
    logic      lookup_flood_o;

    integer      seed = 17458;
    int          value_errs;
    int          other_errs;
    logic [10:0] exp_q [$];      // {err, eof, sof, byte} per expected transfer
    mac_addr_t   exp_dst_q [$];
    mac_addr_t   exp_src_q [$];
    logic [3:0]  lk_q [$];       // {flood, port} per good frame
    port_t       learned [mac_addr_t];  // table model
    logic        rand_ready;
    int          run_left;

    switch_rx_port #(.PORT_ID(TB_PORT)) uut (.*);

    initial begin
        switch_clk = 1'b0;
        forever #(SW_PERIOD / 2) switch_clk = ~switch_clk;
    end

    initial begin
        gmii_rx_clk_i = 1'b0;
        forever #(GMII_PERIOD / 2) gmii_rx_clk_i = ~gmii_rx_clk_i;
    end

    task automatic report_value(input string name, input logic [47:0] exp,
                                input logic [47:0] got);
        value_errs++;
        $display("ERR t=%0t %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic report_fail(input string what);
        other_errs++;
        $display("t=%0t %s", $time, what);
    endtask

    // msb-first crc on the normal polynomial, octet fed lsb first as on the wire
    function automatic crc_t crc_step(input crc_t crc, input byte_t b);
        crc_t c;
        logic fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[31] ^ b[i];
            c  = {c[30:0], 1'b0};
            if (fb) c = c ^ 32'h04C1_1DB7;
        end
        return c;
    endfunction

    function automatic crc_t reflect32(input crc_t c);
        crc_t r;
        for (int i = 0; i < 32; i++) r[i] = c[31 - i];
        return r;
    endfunction

    // lookup first, then learn, same order as one table access
    task automatic expect_lookup(input mac_addr_t dst, input mac_addr_t src);
        logic  flood;
        port_t port;
        flood = dst[MCAST_BIT] || !learned.exists(dst);  // group bit or unknown
        port  = flood ? port_t'(0) : learned[dst];
        lk_q.push_back({flood, port});
        learned[src] = TB_PORT;
    endtask

    task automatic send_frame(input mac_addr_t dst, input mac_addr_t src, input int mode);
        byte_t fr [$];
        crc_t  crc;
        crc_t  fcs;
        int    plen;
        logic  bad;
        plen = 4 + ($random(seed) & 31);
        for (int i = 0; i < 6; i++) fr.push_back(dst[47 - 8 * i -: 8]);
        for (int i = 0; i < 6; i++) fr.push_back(src[47 - 8 * i -: 8]);
        for (int i = 0; i < plen; i++) fr.push_back(byte_t'($random(seed)));
        crc = 32'hFFFF_FFFF;
        foreach (fr[i]) crc = crc_step(crc, fr[i]);
        fcs = ~reflect32(crc);
        for (int i = 0; i < 4; i++) fr.push_back(fcs[8 * i +: 8]);  // low octet first
        if (mode == BAD_FCS) fr[fr.size() - 4] = fr[fr.size() - 4] ^ 8'h01;
        bad = (mode == BAD_FCS) || (mode == RX_ER);
        if (mode != BAD_PRE && mode != BAD_SFD) begin
            foreach (fr[i]) begin
                exp_q.push_back({bad && (i == fr.size() - 1), i == fr.size() - 1,
                                 i == 0, fr[i]});
            end
            exp_dst_q.push_back(dst);
            exp_src_q.push_back(src);
            if (!bad) expect_lookup(dst, src);
        end
        for (int i = 0; i < PREAMBLE_LEN; i++) begin
            @(negedge gmii_rx_clk_i);
            gmii_rx_dv_i   = 1'b1;
            gmii_rx_data_i = (mode == BAD_PRE && i == 2) ? 8'h5F : 8'h55;
        end
        @(negedge gmii_rx_clk_i);
        gmii_rx_data_i = (mode == BAD_SFD) ? 8'hD4 : 8'hD5;
        foreach (fr[i]) begin
            @(negedge gmii_rx_clk_i);
            gmii_rx_data_i = fr[i];
            gmii_rx_er_i   = (mode == RX_ER) && (i == 14);  // one payload octet
        end
        @(negedge gmii_rx_clk_i);
        gmii_rx_dv_i   = 1'b0;
        gmii_rx_er_i   = 1'b0;
        gmii_rx_data_i = '0;
        repeat (IFG) @(negedge gmii_rx_clk_i);
    endtask

    // random stalls, short low runs against long high runs so the fifo never fills
    always @(negedge switch_clk) begin
        if (!rand_ready) begin
            frame_ready_i <= 1'b1;
            run_left      <= 0;
        end else if (run_left > 0) begin
            run_left <= run_left - 1;
        end else if (frame_ready_i) begin
            frame_ready_i <= 1'b0;
            run_left      <= $random(seed) & 1;
        end else begin
            frame_ready_i <= 1'b1;
            run_left      <= 7 + ($random(seed) & 7);
        end
    end

    // byte scoreboard
    always @(posedge switch_clk) begin
        logic [10:0] e;
        if (switch_rst_n && frame_valid_o && frame_ready_i) begin
            if (exp_q.size() == 0) begin
                report_fail("frame byte transferred while no frame was expected");
            end else begin
                e = exp_q.pop_front();
                assert (frame_data_o == e[7:0])
                    else report_value("frame_data_o", e[7:0], frame_data_o);
                assert (frame_sof_o == e[8]) else report_value("frame_sof_o", e[8], frame_sof_o);
                assert (frame_eof_o == e[9]) else report_value("frame_eof_o", e[9], frame_eof_o);
                assert (!e[9] || frame_error_o == e[10])
                    else report_value("frame_error_o", e[10], frame_error_o);
                if (e[9] && exp_dst_q.size() != 0) begin
                    assert (mac_dst_addr_o == exp_dst_q[0])
                        else report_value("mac_dst_addr_o", exp_dst_q[0], mac_dst_addr_o);
                    assert (mac_src_addr_o == exp_src_q[0])
                        else report_value("mac_src_addr_o", exp_src_q[0], mac_src_addr_o);
                    void'(exp_dst_q.pop_front());
                    void'(exp_src_q.pop_front());
                end
            end
        end
    end

    // lookup results against the table model
    always @(posedge switch_clk) begin
        logic [3:0] e;
        if (switch_rst_n && lookup_valid_o && lookup_ready_i) begin
            if (lk_q.size() == 0) begin
                report_fail("lookup result given with no good frame pending");
            end else begin
                e = lk_q.pop_front();
                assert (lookup_flood_o == e[3])
                    else report_value("lookup_flood_o", e[3], lookup_flood_o);
                if (!e[3]) begin
                    assert (lookup_port_o == e[2:0])
                        else report_value("lookup_port_o", e[2:0], lookup_port_o);
                end
            end
        end
    end

    assert property (@(posedge switch_clk) disable iff (!switch_rst_n)
        frame_valid_o && !frame_ready_i |=> frame_valid_o && $stable(frame_data_o)
            && $stable(frame_sof_o) && $stable(frame_eof_o) && $stable(frame_error_o))
        else report_fail("frame output changed during a stall");

    assert property (@(posedge switch_clk) disable iff (!switch_rst_n)
        frame_valid_o && frame_error_o |-> frame_eof_o)
        else report_fail("error flag raised away from the last byte");

    assert property (@(posedge switch_clk) disable iff (!switch_rst_n)
        lookup_valid_o && !lookup_ready_i |=> lookup_valid_o
            && $stable(lookup_port_o) && $stable(lookup_flood_o))
        else report_fail("lookup result changed while held");

    // exactly one cycle from the good eof transfer to the result
    assert property (@(posedge switch_clk) disable iff (!switch_rst_n)
        frame_valid_o && frame_ready_i && frame_eof_o && !frame_error_o
            |=> $rose(lookup_valid_o))
        else report_fail("lookup result missing one cycle after a good frame");

    assert property (@(posedge switch_clk) disable iff (!switch_rst_n)
        $rose(lookup_valid_o) |-> $past(frame_valid_o && frame_ready_i && frame_eof_o))
        else report_fail("lookup result rose without an eof transfer before it");

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all frames were received");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        switch_rst_n   = 1'b0;
        gmii_rx_data_i = '0;
        gmii_rx_dv_i   = 1'b0;
        gmii_rx_er_i   = 1'b0;
        frame_ready_i  = 1'b1;
        lookup_ready_i = 1'b1;
        rand_ready     = 1'b0;
        value_errs     = 0;
        other_errs     = 0;
        repeat (2) @(posedge switch_clk);
        @(negedge switch_clk);
        assert (!frame_valid_o && !frame_sof_o && !frame_eof_o && !frame_error_o
                && !lookup_valid_o)
            else report_fail("stream or lookup outputs not low in reset");
        switch_rst_n = 1'b1;
        repeat (4) @(negedge gmii_rx_clk_i);  // gmii side leaves reset too

        send_frame(ADDR_U, ADDR_A, GOOD);     // unknown dst floods, A learned
        @(negedge switch_clk);
        lookup_ready_i = 1'b0;                // hold the next result
        send_frame(ADDR_A, ADDR_B, GOOD);     // hit on A, port 5
        while (!lookup_valid_o) @(posedge switch_clk);
        repeat (6) @(negedge switch_clk);
        lookup_ready_i = 1'b1;
        send_frame(BCAST, ADDR_C, GOOD);
        send_frame(ADDR_U, ADDR_D, BAD_FCS);
        send_frame(ADDR_D, ADDR_B, GOOD);     // D must still be unknown
        send_frame(ADDR_A, ADDR_E, RX_ER);
        send_frame(ADDR_E, ADDR_C, GOOD);
        send_frame(ADDR_A, ADDR_F, BAD_PRE);
        send_frame(ADDR_A, ADDR_F, BAD_SFD);
        send_frame(ADDR_C, ADDR_A, GOOD);     // normal again after dropped frames

        rand_ready = 1'b1;
        for (int i = 0; i < 6; i++) begin
            send_frame((i % 2) ? ADDR_B : ADDR_F, ADDR_C, GOOD);
        end
        while (exp_q.size() != 0 || lk_q.size() != 0) @(posedge switch_clk);
        rand_ready = 1'b0;
        repeat (10) @(posedge switch_clk);

        $display("value errors %0d, other errors %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/async_fifo.sv */
`default_nettype none

module async_fifo import switch_pkg::*; (
    input  logic       wr_clk_i,
    input  logic       wr_rst_n_i,
    input  logic       wr_en_i,
    input  fifo_word_t wr_data_i,
    output logic       wr_full_o,

    input  logic       rd_clk_i,
    input  logic       rd_rst_n_i,
    input  logic       rd_en_i,
    output fifo_word_t rd_data_o,
    output logic       rd_empty_o
);

    fifo_word_t mem [FIFO_DEPTH];

    fifo_ptr_t wr_bin, wr_gray, wr_bin_nxt, wr_gray_nxt;
    fifo_ptr_t rd_bin, rd_gray, rd_bin_nxt, rd_gray_nxt;
    fifo_ptr_t rd_gray_wsync;  // read pointer seen from the write clock
    fifo_ptr_t wr_gray_rsync;  // write pointer seen from the read clock
    logic      wr_go, rd_go;

    // write domain
    assign wr_go       = wr_en_i && !wr_full_o;  // writes into a full fifo are ignored
    assign wr_bin_nxt  = wr_bin + fifo_ptr_t'(wr_go);
    assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;

    always_ff @(posedge wr_clk_i or negedge wr_rst_n_i) begin
        if (!wr_rst_n_i) begin
            wr_bin    <= '0;
            wr_gray   <= '0;
            wr_full_o <= 1'b0;
        end else begin
            wr_bin  <= wr_bin_nxt;
            wr_gray <= wr_gray_nxt;
            // full when write is one lap ahead, top two gray bits inverted
            wr_full_o <= (wr_gray_nxt == {~rd_gray_wsync[FIFO_AW:FIFO_AW-1],
                                          rd_gray_wsync[FIFO_AW-2:0]});
        end
    end

    always_ff @(posedge wr_clk_i) begin
        if (wr_go) mem[wr_bin[FIFO_AW-1:0]] <= wr_data_i;
    end

    // read domain
    assign rd_go       = rd_en_i && !rd_empty_o;
    assign rd_bin_nxt  = rd_bin + fifo_ptr_t'(rd_go);
    assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;

    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            rd_empty_o <= 1'b1;
        end else begin
            rd_bin     <= rd_bin_nxt;
            rd_gray    <= rd_gray_nxt;
            rd_empty_o <= (rd_gray_nxt == wr_gray_rsync);  // caught up with writer
        end
    end

    always_ff @(posedge rd_clk_i) begin
        if (rd_go) rd_data_o <= mem[rd_bin[FIFO_AW-1:0]];  // valid the cycle after rd_en
    end

    // gray pointers cross one bit change at a time
    synchronizer #(.WIDTH(FIFO_AW + 1)) sync_rd_ptr (
        .clk_i   (wr_clk_i),
        .rst_n_i (wr_rst_n_i),
        .d_i     (rd_gray),
        .q_o     (rd_gray_wsync)
    );

    synchronizer #(.WIDTH(FIFO_AW + 1)) sync_wr_ptr (
        .clk_i   (rd_clk_i),
        .rst_n_i (rd_rst_n_i),
        .d_i     (wr_gray),
        .q_o     (wr_gray_rsync)
    );

endmodule

`default_nettype wire

/* source/eth_pkg.sv */
`default_nettype none

package eth_pkg;

    typedef logic [7:0]  byte_t;      // one octet on the wire
    typedef logic [47:0] mac_addr_t;  // first received octet in [47:40]
    typedef logic [31:0] crc_t;

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;
    localparam int    PREAMBLE_LEN  = 7;  // preamble octets before the SFD
    localparam int    ADDR_BYTES    = 6;  // octets per MAC address

    // I/G bit, lsb of the first octet, set for multicast and broadcast
    localparam int MCAST_BIT = 40;

    localparam crc_t CRC_POLY    = 32'hEDB8_8320;  // reflected 802.3 polynomial
    localparam crc_t CRC_INIT    = 32'hFFFF_FFFF;
    // register value once a correct FCS has been shifted through
    localparam crc_t CRC_RESIDUE = 32'hDEBB_20E3;

    // lsb-first crc update, one octet per call
    function automatic crc_t crc32_next(input byte_t data, input crc_t crc);
        crc_t c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

/* source/mac_lookup.sv */
`default_nettype none

module mac_lookup import eth_pkg::*; import switch_pkg::*; #(
    parameter port_t PORT_ID = '0
) (
    input  logic      switch_clk,
    input  logic      switch_rst_n,
    input  logic      hdr_done_i,
    input  logic      frame_good_i,
    input  mac_addr_t mac_dst_addr_i,
    input  mac_addr_t mac_src_addr_i,
    output logic      lookup_valid_o,
    input  logic      lookup_ready_i,
    output port_t     lookup_port_o,
    output logic      lookup_flood_o
);

    logic [TABLE_DEPTH-1:0] ent_vld;
    mac_addr_t              ent_addr [TABLE_DEPTH];
    port_t                  ent_port [TABLE_DEPTH];

    logic [TABLE_IDX_W-1:0] repl_ptr;   // round-robin victim
    logic [TABLE_IDX_W-1:0] dst_idx, src_idx;
    logic                   dst_hit, src_hit;
    logic                   accept;

    // parallel compare of both addresses against every entry
    always_comb begin
        dst_hit = 1'b0;
        dst_idx = '0;
        src_hit = 1'b0;
        src_idx = '0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (ent_vld[i] && ent_addr[i] == mac_dst_addr_i) begin
                dst_hit = 1'b1;
                dst_idx = TABLE_IDX_W'(i);
            end
            if (ent_vld[i] && ent_addr[i] == mac_src_addr_i) begin
                src_hit = 1'b1;
                src_idx = TABLE_IDX_W'(i);
            end
        end
    end

    // bad frames and frames arriving behind a held result are dropped
    assign accept = hdr_done_i && frame_good_i && !(lookup_valid_o && !lookup_ready_i);

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            lookup_valid_o <= 1'b0;
            ent_vld        <= '0;
            repl_ptr       <= '0;
        end else begin
            if (accept) begin
                lookup_valid_o <= 1'b1;   // one cycle after hdr_done
            end else if (lookup_ready_i) begin
                lookup_valid_o <= 1'b0;
            end
            if (accept && !src_hit) begin
                ent_vld[repl_ptr] <= 1'b1;
                repl_ptr          <= repl_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge switch_clk) begin
        if (accept) begin
            lookup_port_o  <= dst_hit ? ent_port[dst_idx] : '0;
            lookup_flood_o <= mac_dst_addr_i[MCAST_BIT] || !dst_hit;  // group or unknown
            if (src_hit) begin
                ent_port[src_idx] <= PORT_ID;  // refresh, station may have moved
            end else begin
                ent_addr[repl_ptr] <= mac_src_addr_i;
                ent_port[repl_ptr] <= PORT_ID;
            end
        end
    end

endmodule

`default_nettype wire

/* source/rx_mac_control.sv */
`default_nettype none

module rx_mac_control import eth_pkg::*; import switch_pkg::*; (
    input  logic      gmii_rx_clk_i,
    input  byte_t     gmii_rx_data_i,
    input  logic      gmii_rx_dv_i,
    input  logic      gmii_rx_er_i,

    input  logic      switch_clk,
    input  logic      switch_rst_n,

    output mac_addr_t mac_dst_addr_o,
    output mac_addr_t mac_src_addr_o,

    output byte_t     frame_data_o,
    output logic      frame_valid_o,
    input  logic      frame_ready_i,
    output logic      frame_sof_o,   // first destination byte
    output logic      frame_eof_o,   // last fcs byte
    output logic      frame_error_o, // only meaningful with eof

    output logic      hdr_done_o,    // eof byte transferred
    output logic      frame_good_o
);

    typedef enum logic [1:0] {IDLE, PREAMBLE, HEADER, PAYLOAD} rx_state_t;

    // gmii clock domain
    logic       gmii_rst_n;   // switch reset, released in gmii clock
    byte_t      rx_byte_q;    // byte held back one cycle to see dv fall
    logic       rx_dv_q;
    logic       rx_er_seen;   // er seen somewhere in this frame
    logic       drop_pend;    // a word was lost to a full fifo
    logic       wr_last;
    logic       fifo_full;
    fifo_word_t wr_word;

    // switch clock domain
    fifo_word_t rd_word;
    logic       fifo_empty, fifo_rd_en;
    byte_t      w_byte;
    logic       w_last, w_err;
    rx_state_t  state;
    logic [3:0] byte_cnt;     // preamble count, then header byte index
    logic       word_vld;     // rd_word holds a byte not yet used
    logic       err_acc;      // error marks collected since the first preamble byte
    logic       in_data, out_free, consume, load, bad_end;
    crc_t       crc_q, crc_nxt;

    synchronizer #(.WIDTH(1)) sync_rst (
        .clk_i   (gmii_rx_clk_i),
        .rst_n_i (switch_rst_n),
        .d_i     (1'b1),
        .q_o     (gmii_rst_n)
    );

    assign wr_last = rx_dv_q && !gmii_rx_dv_i;  // held byte is the final one
    assign wr_word = {rx_er_seen || drop_pend, wr_last, rx_byte_q};

    always_ff @(posedge gmii_rx_clk_i or negedge gmii_rst_n) begin
        if (!gmii_rst_n) begin
            rx_dv_q    <= 1'b0;
            rx_er_seen <= 1'b0;
            drop_pend  <= 1'b0;
        end else begin
            rx_dv_q <= gmii_rx_dv_i;
            if (wr_last) begin
                rx_er_seen <= 1'b0;  // frame closed, mark already written
            end else if (gmii_rx_dv_i && gmii_rx_er_i) begin
                rx_er_seen <= 1'b1;
            end
            if (rx_dv_q) drop_pend <= fifo_full;  // cleared by the next word that fits
        end
    end

    always_ff @(posedge gmii_rx_clk_i) begin
        rx_byte_q <= gmii_rx_data_i;
    end

    async_fifo cdc_fifo (
        .wr_clk_i   (gmii_rx_clk_i),
        .wr_rst_n_i (gmii_rst_n),
        .wr_en_i    (rx_dv_q),
        .wr_data_i  (wr_word),
        .wr_full_o  (fifo_full),
        .rd_clk_i   (switch_clk),
        .rd_rst_n_i (switch_rst_n),
        .rd_en_i    (fifo_rd_en),
        .rd_data_o  (rd_word),
        .rd_empty_o (fifo_empty)
    );

    assign w_byte = rd_word[7:0];
    assign w_last = rd_word[FIFO_LAST_BIT];
    assign w_err  = rd_word[FIFO_ERR_BIT];

    assign in_data  = (state == HEADER) || (state == PAYLOAD);
    assign out_free = !frame_valid_o || frame_ready_i;  // output slot empties this edge
    assign consume  = word_vld && (!in_data || out_free); // preamble never waits on ready
    assign load     = consume && in_data;
    // fetch only when the word in hand goes away, so a stall stops the fifo
    assign fifo_rd_en = !fifo_empty && (!word_vld || consume);

    assign crc_nxt = crc32_next(w_byte, crc_q);
    // a last mark still in HEADER is a runt
    assign bad_end = (crc_nxt != CRC_RESIDUE) || err_acc || w_err || (state == HEADER);

    assign hdr_done_o   = frame_valid_o && frame_ready_i && frame_eof_o;
    assign frame_good_o = !frame_error_o;

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            state         <= IDLE;
            byte_cnt      <= '0;
            word_vld      <= 1'b0;
            err_acc       <= 1'b0;
            frame_valid_o <= 1'b0;
            frame_sof_o   <= 1'b0;
            frame_eof_o   <= 1'b0;
            frame_error_o <= 1'b0;
        end else begin
            if (fifo_rd_en) begin
                word_vld <= 1'b1;
            end else if (consume) begin
                word_vld <= 1'b0;
            end

            if (frame_valid_o && frame_ready_i) frame_valid_o <= 1'b0;
            if (load) begin
                frame_valid_o <= 1'b1;
                frame_sof_o   <= (state == HEADER) && (byte_cnt == '0);
                frame_eof_o   <= w_last;
                frame_error_o <= w_last && bad_end;
            end

            if (consume) begin
                err_acc <= err_acc || w_err;
                case (state)
                    IDLE: begin
                        if (w_byte == PREAMBLE_BYTE && !w_last) begin
                            state    <= PREAMBLE;
                            byte_cnt <= 4'd1;
                            err_acc  <= w_err;  // start of a new frame
                        end
                    end
                    PREAMBLE: begin
                        byte_cnt <= byte_cnt + 4'd1;
                        if (w_last) begin
                            state <= IDLE;
                        end else if (byte_cnt == 4'(PREAMBLE_LEN)) begin
                            if (w_byte == SFD_BYTE) begin
                                state    <= HEADER;
                                byte_cnt <= '0;
                            end else begin
                                state <= IDLE;   // bad sfd
                            end
                        end else if (w_byte != PREAMBLE_BYTE) begin
                            state <= IDLE;
                        end
                    end
                    HEADER: begin
                        byte_cnt <= byte_cnt + 4'd1;
                        if (w_last) begin
                            state <= IDLE;
                        end else if (byte_cnt == 4'(2 * ADDR_BYTES - 1)) begin
                            state <= PAYLOAD;    // both addresses in
                        end
                    end
                    PAYLOAD: begin
                        if (w_last) state <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge switch_clk) begin
        if (consume && state == PREAMBLE) crc_q <= CRC_INIT;  // seeded during preamble
        if (load) begin
            frame_data_o <= w_byte;
            crc_q        <= crc_nxt;  // runs over fcs too, ends on the residue
            if (state == HEADER) begin
                if (byte_cnt < 4'(ADDR_BYTES)) begin
                    mac_dst_addr_o <= {mac_dst_addr_o[39:0], w_byte};
                end else begin
                    mac_src_addr_o <= {mac_src_addr_o[39:0], w_byte};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/switch_pkg.sv */
`default_nettype none

package switch_pkg;

    localparam int NUM_PORTS = 8;
    typedef logic [$clog2(NUM_PORTS)-1:0] port_t;  // switch port number

    localparam int TABLE_DEPTH = 8;  // learning table entries
    localparam int TABLE_IDX_W = $clog2(TABLE_DEPTH);

    // cdc fifo word is {err, last, byte}
    typedef logic [9:0] fifo_word_t;
    localparam int FIFO_LAST_BIT = 8;
    localparam int FIFO_ERR_BIT  = 9;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    typedef logic [FIFO_AW:0] fifo_ptr_t;  // extra msb tells wrap for full/empty

endpackage

`default_nettype wire

/* source/switch_rx_port.sv */
`default_nettype none

module switch_rx_port import eth_pkg::*; import switch_pkg::*; #(
    parameter port_t PORT_ID = '0
) (
    input  logic      gmii_rx_clk_i,
    input  byte_t     gmii_rx_data_i,
    input  logic      gmii_rx_dv_i,
    input  logic      gmii_rx_er_i,

    input  logic      switch_clk,
    input  logic      switch_rst_n,

    output byte_t     frame_data_o,
    output logic      frame_valid_o,
    input  logic      frame_ready_i,
    output logic      frame_sof_o,
    output logic      frame_eof_o,
    output logic      frame_error_o,

    output mac_addr_t mac_dst_addr_o,
    output mac_addr_t mac_src_addr_o,

    output logic      lookup_valid_o,
    input  logic      lookup_ready_i,
    output port_t     lookup_port_o,
    output logic      lookup_flood_o
);

    logic hdr_done;    // eof transfer, kicks off the table access
    logic frame_good;

    rx_mac_control u_rx_mac (
        .gmii_rx_clk_i  (gmii_rx_clk_i),
        .gmii_rx_data_i (gmii_rx_data_i),
        .gmii_rx_dv_i   (gmii_rx_dv_i),
        .gmii_rx_er_i   (gmii_rx_er_i),
        .switch_clk     (switch_clk),
        .switch_rst_n   (switch_rst_n),
        .mac_dst_addr_o (mac_dst_addr_o),
        .mac_src_addr_o (mac_src_addr_o),
        .frame_data_o   (frame_data_o),
        .frame_valid_o  (frame_valid_o),
        .frame_ready_i  (frame_ready_i),
        .frame_sof_o    (frame_sof_o),
        .frame_eof_o    (frame_eof_o),
        .frame_error_o  (frame_error_o),
        .hdr_done_o     (hdr_done),
        .frame_good_o   (frame_good)
    );

    mac_lookup #(.PORT_ID(PORT_ID)) u_lookup (
        .switch_clk     (switch_clk),
        .switch_rst_n   (switch_rst_n),
        .hdr_done_i     (hdr_done),
        .frame_good_i   (frame_good),
        .mac_dst_addr_i (mac_dst_addr_o),
        .mac_src_addr_i (mac_src_addr_o),
        .lookup_valid_o (lookup_valid_o),
        .lookup_ready_i (lookup_ready_i),
        .lookup_port_o  (lookup_port_o),
        .lookup_flood_o (lookup_flood_o)
    );

endmodule

`default_nettype wire

/* source/synchronizer.sv */
`default_nettype none

module synchronizer #(
    parameter int WIDTH = 1
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic [WIDTH-1:0] d_i,
    output logic [WIDTH-1:0] q_o
);

    logic [WIDTH-1:0] meta;  // first stage, may go metastable

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meta <= '0;
            q_o  <= '0;
        end else begin
            meta <= d_i;
            q_o  <= meta;  // settled copy
        end
    end

endmodule

`default_nettype wire

/* switch_rx_port.f */
source/eth_pkg.sv
source/switch_pkg.sv
source/synchronizer.sv
source/async_fifo.sv
source/rx_mac_control.sv
source/mac_lookup.sv
source/switch_rx_port.sv
sim/tb_switch_rx_port.sv
